// File: common/uart_pkg.sv
// Shared UART types and register map; AXI addresses are 4 bits wide, so only offsets 0x0 to 0xC exist.
package uart_pkg;

	// One serial data byte.
	typedef logic [7:0] byte_t;

	// AXI4-Lite byte address, data word and response code.
	typedef logic [3:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0] axi_resp_t;

	// Response codes.
	localparam axi_resp_t resp_okay = 2'b00;
	localparam axi_resp_t resp_slverr = 2'b10;

	// Register offsets.
	localparam axi_addr_t reg_data = 4'h0; // Write sends a byte, read pops one.
	localparam axi_addr_t reg_status = 4'h4; // Read only, clears sticky flags.

	// Status register bit positions.
	localparam int unsigned st_tx_busy = 0;
	localparam int unsigned st_rx_valid = 1;
	localparam int unsigned st_overrun = 2;
	localparam int unsigned st_frame_err = 3;

endpackage

// File: uart/uart_tx.sv
// 8N1 serializer, LSB first; bit_period must be at least 1 and tx_start is only legal while idle.
`timescale 1ns/1ps

module uart_tx #(
	parameter int div_width = 4,
	parameter int bit_period = 15
) (
	input logic clk,
	input logic rst_n,
	input logic tx_start,
	input uart_pkg::byte_t tx_data,
	output logic tx_busy,
	output logic txd
);

	typedef logic [div_width-1:0] div_t;
	typedef enum logic [1:0] {s_idle, s_shift, s_wait} tx_state_t;

	// Reload value; the shift edge counts as the first cycle of a bit.
	localparam div_t div_reload = div_t'(bit_period - 1);

	tx_state_t state;
	div_t divcnt;
	logic [3:0] bitcnt; // Shifts still to do in this frame.
	logic [9:0] shreg; // Data, start, idle bit; bit 0 drives the line, ones shift in behind.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			divcnt <= '0;
			bitcnt <= '0;
			shreg <= '1;
		end else begin
			case (state)
				s_idle:
					if (tx_start) begin
						shreg <= {tx_data, 1'b0, 1'b1}; // Start bit goes out on the next edge.
						bitcnt <= 4'd10;
						state <= s_shift;
					end

				s_wait:
					if (divcnt != '0) begin
						divcnt <= divcnt - 1'b1;
					end else begin
						state <= s_shift;
					end

				s_shift:
					if (bitcnt == '0) begin
						state <= s_idle; // Stop bit has run its full length.
					end else begin
						shreg <= {1'b1, shreg[9:1]};
						bitcnt <= bitcnt - 1'b1;
						divcnt <= div_reload;
						state <= s_wait;
					end

				default:
					state <= s_idle;
			endcase
		end
	end

	// Busy as soon as a start request is seen.
	assign tx_busy = (state != s_idle) || tx_start;
	assign txd = shreg[0];

	// The register block must hold off new bytes until the frame is done.
	a_start_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		tx_start |-> state == s_idle
	) else $error("uart_tx: tx_start while a frame is in progress");

endmodule

// File: uart/uart_rx.sv
// 8N1 deserializer with one sample per bit at mid-bit; a frame error with the line held low restarts reception.
`timescale 1ns/1ps

module uart_rx #(
	parameter int div_width = 4,
	parameter int bit_period = 15
) (
	input logic clk,
	input logic rst_n,
	input logic rxd,
	output logic rx_strobe,
	output uart_pkg::byte_t rx_data,
	output logic rx_frame_err
);

	import uart_pkg::*;

	typedef logic [div_width-1:0] div_t;
	typedef enum logic [1:0] {s_idle, s_start, s_data} rx_state_t;

	localparam div_t div_half = div_t'(bit_period / 2);
	localparam div_t div_full = div_t'(bit_period);

	rx_state_t state;
	div_t divcnt;
	logic [3:0] bitcnt; // Samples taken since mid start bit.
	logic rxd_meta;
	logic rxd_sync;
	byte_t shreg;

	// Two flop synchronizer, idles high.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			divcnt <= '0;
			bitcnt <= '0;
			rx_strobe <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			rx_frame_err <= 1'b0;
			case (state)
				s_idle:
					if (!rxd_sync) begin
						divcnt <= div_half;
						state <= s_start;
					end

				s_start:
					if (rxd_sync) begin
						state <= s_idle; // Glitch, line went back high.
					end else if (divcnt != '0) begin
						divcnt <= divcnt - 1'b1;
					end else begin
						divcnt <= div_full; // Mid start bit confirmed.
						bitcnt <= '0;
						state <= s_data;
					end

				s_data:
					if (divcnt != '0) begin
						divcnt <= divcnt - 1'b1;
					end else if (bitcnt == 4'd8) begin
						state <= s_idle;
						// Stop bit decides whether the byte is kept.
						if (rxd_sync) begin
							rx_strobe <= 1'b1;
						end else begin
							rx_frame_err <= 1'b1;
						end
					end else begin
						divcnt <= div_full;
						bitcnt <= bitcnt + 1'b1;
					end

				default:
					state <= s_idle;
			endcase
		end
	end

	// Data shift register and output byte.
	always_ff @(posedge clk) begin
		if (state == s_data && divcnt == '0) begin
			if (bitcnt == 4'd8) begin
				rx_data <= shreg;
			end else begin
				shreg <= {rxd_sync, shreg[7:1]}; // LSB arrives first.
			end
		end
	end

	a_one_outcome: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(rx_strobe && rx_frame_err)
	) else $error("uart_rx: byte strobe and frame error in the same cycle");

endmodule

// File: uart/uart_rx_fifo.sv
// First-word-fall-through byte FIFO; fifo_depth must be a power of two and at least 2.
`timescale 1ns/1ps

module uart_rx_fifo #(
	parameter int fifo_depth = 4
) (
	input logic clk,
	input logic rst_n,
	input logic rx_strobe,
	input uart_pkg::byte_t rx_data,
	input logic fifo_pop,
	output uart_pkg::byte_t fifo_data,
	output logic fifo_valid,
	output logic fifo_overrun
);

	import uart_pkg::*;

	localparam int ptr_width = $clog2(fifo_depth);

	byte_t mem [fifo_depth];
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == (ptr_width + 1)'(fifo_depth));
	assign pop = fifo_pop && fifo_valid;
	assign push = rx_strobe && (!full || pop); // A pop frees a slot this edge.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap on their own.
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= rx_data;
	end

	assign fifo_data = mem[rd_ptr];
	assign fifo_valid = (count != '0);
	assign fifo_overrun = rx_strobe && !push; // Byte dropped.

	a_count_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		count <= (ptr_width + 1)'(fifo_depth)
	) else $error("uart_rx_fifo: occupancy above depth");

endmodule

// File: verilog/uart_regs.sv
// AXI4-Lite register block, one outstanding transfer per channel; only wstrb[0] matters for data writes.
`timescale 1ns/1ps

module uart_regs (
	input logic clk,
	input logic rst_n,
	input uart_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input uart_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output uart_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input uart_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output uart_pkg::axi_data_t rdata,
	output uart_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	output logic tx_start,
	output uart_pkg::byte_t tx_data,
	input logic tx_busy,
	input uart_pkg::byte_t fifo_data,
	input logic fifo_valid,
	input logic fifo_overrun,
	output logic fifo_pop,
	input logic rx_frame_err
);

	import uart_pkg::*;

	typedef enum logic [1:0] {w_idle, w_accept, w_resp} wr_state_t;
	typedef enum logic [1:0] {r_idle, r_accept, r_resp} rd_state_t;

	wr_state_t w_state;
	rd_state_t r_state;
	logic wr_fire;
	logic rd_fire;
	logic status_rd;
	logic overrun_q;
	logic frame_err_q;
	axi_data_t status_word;

	assign awready = (w_state == w_accept);
	assign wready = (w_state == w_accept);
	assign bvalid = (w_state == w_resp);
	assign arready = (r_state == r_accept);
	assign rvalid = (r_state == r_resp);

	assign wr_fire = awready && awvalid && wvalid;
	assign rd_fire = arready && arvalid;
	assign status_rd = rd_fire && (araddr == reg_status);
	assign fifo_pop = rd_fire && (araddr == reg_data) && fifo_valid;

	// Write channel.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_state <= w_idle;
			bresp <= resp_okay;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (w_state)
				w_idle:
					if (awvalid && wvalid) w_state <= w_accept;

				w_accept:
					if (wr_fire) begin
						w_state <= w_resp;
						bresp <= resp_okay;
						if (awaddr == reg_data) begin
							if (tx_busy) begin
								bresp <= resp_slverr; // Byte discarded.
							end else if (wstrb[0]) begin
								tx_start <= 1'b1;
							end
						end else if (awaddr != reg_status) begin
							bresp <= resp_slverr;
						end
					end

				w_resp:
					if (bready) w_state <= w_idle;

				default:
					w_state <= w_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && awaddr == reg_data) tx_data <= wdata[7:0];
	end

	// Read channel.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_state <= r_idle;
			rresp <= resp_okay;
		end else begin
			case (r_state)
				r_idle:
					if (arvalid) r_state <= r_accept;

				r_accept:
					if (rd_fire) begin
						r_state <= r_resp;
						if (araddr == reg_data || araddr == reg_status) begin
							rresp <= resp_okay;
						end else begin
							rresp <= resp_slverr;
						end
					end

				r_resp:
					if (rready) r_state <= r_idle;

				default:
					r_state <= r_idle;
			endcase
		end
	end

	always_comb begin
		status_word = '0;
		status_word[st_tx_busy] = tx_busy;
		status_word[st_rx_valid] = fifo_valid;
		status_word[st_overrun] = overrun_q;
		status_word[st_frame_err] = frame_err_q;
	end

	// Read data, held while rvalid waits for rready.
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			case (araddr)
				reg_data: rdata <= fifo_valid ? {24'd0, fifo_data} : '0;
				reg_status: rdata <= status_word;
				default: rdata <= '0;
			endcase
		end
	end

	// Sticky flags, a new event beats the clear.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			overrun_q <= 1'b0;
			frame_err_q <= 1'b0;
		end else begin
			if (fifo_overrun) overrun_q <= 1'b1;
			else if (status_rd) overrun_q <= 1'b0;
			if (rx_frame_err) frame_err_q <= 1'b1;
			else if (status_rd) frame_err_q <= 1'b0;
		end
	end

	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid
	) else $error("uart_regs: bvalid dropped before bready");

endmodule

// File: verilog/uart_top.sv
// UART peripheral top; clk_hz/baud must be at least 2 and the baud rate is fixed at elaboration.
`timescale 1ns/1ps

module uart_top #(
	parameter int clk_hz = 50_000_000,
	parameter int baud = 115_200,
	parameter int fifo_depth = 4
) (
	input logic clk,
	input logic rst_n,
	input uart_pkg::axi_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input uart_pkg::axi_data_t wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output uart_pkg::axi_resp_t bresp,
	output logic bvalid,
	input logic bready,
	input uart_pkg::axi_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output uart_pkg::axi_data_t rdata,
	output uart_pkg::axi_resp_t rresp,
	output logic rvalid,
	input logic rready,
	output logic txd,
	input logic rxd
);

	import uart_pkg::*;

	localparam int bit_period = clk_hz / baud - 1; // Cycles per bit, minus one.
	localparam int div_width = $clog2(bit_period + 1);

	logic tx_start;
	byte_t tx_data;
	logic tx_busy;
	logic rx_strobe;
	byte_t rx_data;
	logic rx_frame_err;
	byte_t fifo_data;
	logic fifo_valid;
	logic fifo_overrun;
	logic fifo_pop;

	uart_regs regs (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy),
		.fifo_data(fifo_data), .fifo_valid(fifo_valid),
		.fifo_overrun(fifo_overrun), .fifo_pop(fifo_pop),
		.rx_frame_err(rx_frame_err)
	);

	uart_tx #(.div_width(div_width), .bit_period(bit_period)) tx (
		.clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
		.tx_busy(tx_busy), .txd(txd)
	);

	uart_rx #(.div_width(div_width), .bit_period(bit_period)) rx (
		.clk(clk), .rst_n(rst_n), .rxd(rxd), .rx_strobe(rx_strobe),
		.rx_data(rx_data), .rx_frame_err(rx_frame_err)
	);

	uart_rx_fifo #(.fifo_depth(fifo_depth)) rx_fifo (
		.clk(clk), .rst_n(rst_n), .rx_strobe(rx_strobe), .rx_data(rx_data),
		.fifo_pop(fifo_pop), .fifo_data(fifo_data), .fifo_valid(fifo_valid),
		.fifo_overrun(fifo_overrun)
	);

endmodule

// File: testbench/uart_tb_tasks.svh
// AXI4-Lite and serial line helpers; they start and end 2 ns after a rising edge and need uart_tb scope.
task automatic axi_write(input axi_addr_t addr, input axi_data_t data, output axi_resp_t resp,
		output int hs_cycle);
	int n;
	awaddr = addr;
	wdata = data;
	wstrb = 4'hf;
	awvalid = 1'b1;
	wvalid = 1'b1;
	bready = 1'b1;
	for (n = 0; n < 50 && !awready; n++)
		@(negedge clk);
	expect_true(awready, "awready never rose during a write");
	@(posedge clk); // Address and data handshake.
	#2;
	hs_cycle = cycle;
	awvalid = 1'b0;
	wvalid = 1'b0;
	for (n = 0; n < 50 && !bvalid; n++)
		@(negedge clk);
	expect_true(bvalid, "bvalid never rose after a write");
	resp = bresp;
	@(posedge clk);
	#2;
	bready = 1'b0;
endtask

// Hold stretches rready low for that many cycles once rvalid is up.
task automatic axi_read(input axi_addr_t addr, input int hold, output axi_data_t data,
		output axi_resp_t resp);
	int n;
	araddr = addr;
	arvalid = 1'b1;
	for (n = 0; n < 50 && !arready; n++)
		@(negedge clk);
	expect_true(arready, "arready never rose during a read");
	@(posedge clk);
	#2;
	arvalid = 1'b0;
	for (n = 0; n < 50 && !rvalid; n++)
		@(negedge clk);
	expect_true(rvalid, "rvalid never rose after a read");
	repeat (hold) @(negedge clk);
	data = rdata;
	resp = rresp;
	@(posedge clk);
	#2;
	rready = 1'b1;
	@(posedge clk); // Read data handshake.
	#2;
	rready = 1'b0;
endtask

task automatic send_frame(input byte_t value, input logic stop_low, input logic glitch);
	logic [9:0] bits;
	int i;
	bits = {~stop_low, value, 1'b0};
	if (glitch) begin
		rxd = 1'b0; // A quarter bit, well short of mid-bit.
		repeat (bit_cycles / 4) step();
		rxd = 1'b1;
		repeat (2 * bit_cycles) step();
	end else begin
		for (i = 0; i < 10; i++) begin
			rxd = bits[i];
			repeat (bit_cycles) step();
		end
		rxd = 1'b1;
	end
endtask

// Samples txd on every falling edge of the frame and decodes at mid-bit.
task automatic catch_frame(output byte_t value, output int start_cycle);
	logic line [10 * bit_cycles];
	int n;
	int b;
	for (n = 0; n < 400 && txd; n++)
		@(negedge clk);
	expect_true(!txd, "no start bit appeared on txd");
	start_cycle = cycle;
	for (n = 0; n < 10 * bit_cycles; n++) begin
		line[n] = txd;
		if (n < 10 * bit_cycles - 1)
			@(negedge clk);
	end
	for (b = 0; b < 10; b++) begin
		for (n = 0; n < bit_cycles; n++) begin
			expect_true(line[b * bit_cycles + n] === line[b * bit_cycles + bit_cycles / 2],
				$sformatf("txd changed inside bit %0d of a frame", b));
		end
	end
	expect_true(line[bit_cycles / 2] === 1'b0, "start bit on txd was not low");
	expect_true(line[9 * bit_cycles + bit_cycles / 2] === 1'b1, "stop bit on txd was not high");
	for (b = 0; b < 8; b++)
		value[b] = line[(b + 1) * bit_cycles + bit_cycles / 2];
	step();
endtask

// File: testbench/uart_tb.sv
// Testbench for uart_top at 16 clocks per bit with a four byte FIFO; a watchdog bounds the run.
`timescale 1ns/1ps

module uart_tb;

	import uart_pkg::*;

	localparam int bit_cycles = 16; // 50 MHz over 3.125 Mbaud.
	localparam int clk_period = 20;
	localparam longint watchdog_ns = 64'd2 * 40 * 10 * bit_cycles * clk_period;

	logic clk;
	logic rst_n;
	axi_addr_t awaddr;
	logic awvalid;
	logic awready;
	axi_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	axi_resp_t bresp;
	logic bvalid;
	logic bready;
	axi_addr_t araddr;
	logic arvalid;
	logic arready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic rvalid;
	logic rready;
	logic txd;
	logic rxd;

	int errors = 0;
	int cycle = 0;
	int seed = 73;
	byte_t sent [$]; // Bytes on rxd that the FIFO should still hold.

	uart_top #(.clk_hz(50_000_000), .baud(3_125_000), .fifo_depth(4)) UUT (
		.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.txd(txd), .rxd(rxd)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name,
				expected, actual);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("At %0t ns: %s", $time, what);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	`include "uart_tb_tasks.svh"

	task automatic read_status(output axi_data_t data);
		axi_resp_t resp;
		axi_read(reg_status, 0, data, resp);
		check_value("status rresp", resp_okay, resp);
	endtask

	// Keep set means the byte is expected back from the FIFO.
	task automatic send_random(input int n, input logic keep);
		byte_t value;
		repeat (n) begin
			value = byte_t'($random(seed));
			if (keep)
				sent.push_back(value);
			send_frame(value, 1'b0, 1'b0);
		end
	endtask

	task automatic drain_and_compare(input int n);
		axi_data_t data;
		axi_resp_t resp;
		repeat (n) begin
			axi_read(reg_data, 0, data, resp);
			check_value("rdata", {24'd0, sent.pop_front()}, data);
			check_value("rresp", resp_okay, resp);
		end
	endtask

	a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		errors++;
		$display("At %0t ns: read response changed before rready", $time);
	end

	a_write_ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
		awready == wready)
	else begin
		errors++;
		$display("At %0t ns: awready and wready differ", $time);
	end

	a_txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		!UUT.tx_busy |-> txd)
	else begin
		errors++;
		$display("At %0t ns: txd low while the transmitter is idle", $time);
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired with the tests unfinished, %0d errors so far", errors);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		axi_data_t data;
		axi_resp_t resp;
		byte_t b;
		byte_t got;
		int hs;
		int late_hs;
		int start;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rxd = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		step();

		// Transmit, with a status read while the frame is on the line.
		b = byte_t'($random(seed));
		axi_write(reg_data, {24'd0, b}, resp, hs);
		check_value("bresp", resp_okay, resp);
		fork
			catch_frame(got, start);
			begin
				read_status(data);
				check_value("status tx_busy", 1, data[st_tx_busy]);
			end
		join
		check_value("txd start cycle", hs + 2, start);
		check_value("txd byte", b, got);
		read_status(data);
		check_value("status tx_busy", 0, data[st_tx_busy]);

		// Receive order.
		send_random(3, 1'b1);
		read_status(data);
		check_value("status rx_valid", 1, data[st_rx_valid]);
		drain_and_compare(3);
		read_status(data);
		check_value("status rx_valid", 0, data[st_rx_valid]);

		// Overrun, the fifth byte is dropped.
		send_random(4, 1'b1);
		send_random(1, 1'b0);
		read_status(data);
		check_value("status overrun", 1, data[st_overrun]);
		drain_and_compare(4);
		read_status(data);
		check_value("status overrun", 0, data[st_overrun]);
		check_value("status rx_valid", 0, data[st_rx_valid]);

		// Low stop bit, then a short glitch.
		send_frame(byte_t'($random(seed)), 1'b1, 1'b0);
		read_status(data);
		check_value("status frame_err", 1, data[st_frame_err]);
		check_value("status rx_valid", 0, data[st_rx_valid]);
		read_status(data);
		check_value("status frame_err", 0, data[st_frame_err]);
		send_frame(8'h00, 1'b0, 1'b1);
		read_status(data);
		check_value("status frame_err", 0, data[st_frame_err]);
		check_value("status rx_valid", 0, data[st_rx_valid]);

		// Error responses.
		b = byte_t'($random(seed));
		axi_write(reg_data, {24'd0, b}, resp, hs);
		check_value("bresp", resp_okay, resp);
		fork
			catch_frame(got, start);
			begin
				read_status(data);
				check_value("status tx_busy", 1, data[st_tx_busy]);
				axi_write(reg_data, {24'd0, ~b}, resp, late_hs);
				check_value("bresp", resp_slverr, resp);
			end
		join
		check_value("txd start cycle", hs + 2, start);
		check_value("txd byte", b, got);
		expect_true(late_hs < start + 10 * bit_cycles,
			"the rejected write was not made while the frame was on txd");
		axi_write(4'h8, 32'h0000_005a, resp, hs);
		check_value("bresp", resp_slverr, resp);
		axi_read(4'h8, 0, data, resp);
		check_value("rresp", resp_slverr, resp);
		check_value("rdata", 0, data);

		// Back-pressure, a second byte lands while rready is held low.
		send_random(1, 1'b1);
		fork
			axi_read(reg_data, 12 * bit_cycles, data, resp);
			send_random(1, 1'b1);
		join
		check_value("rdata", {24'd0, sent.pop_front()}, data);
		drain_and_compare(1);

		$display("Test run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+testbench
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_rx_fifo.sv
verilog/uart_regs.sv
verilog/uart_top.sv
testbench/uart_tb.sv
